/* hw/rv_board_pkg.sv */
`default_nettype none

package rv_board_pkg;

    // one machine word, register values and alu results
    typedef logic [31:0] xlen_t;

    // byte address on the bus and in the pc
    typedef logic [31:0] addr_t;

    // raw instruction word as it comes off the bus
    typedef logic [31:0] instr_t;

    typedef logic [4:0] reg_idx_t;

    // green led byte
    typedef logic [7:0] led_t;

    // byte lane selects, classic 32-bit bus
    typedef logic [3:0] wb_sel_t;

    // instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // stores to this address land on LEDG
    localparam addr_t led_addr = 32'h0000_1000;

    // first fetch after reset
    localparam addr_t reset_pc = 32'h0000_0000;

    // instruction fetches always read the whole word
    localparam wb_sel_t wb_sel_all = 4'b1111;

    // major opcodes of the supported subset
    localparam opcode_t op_lui   = 7'b0110111;
    localparam opcode_t op_imm   = 7'b0010011;
    localparam opcode_t op_reg   = 7'b0110011;
    localparam opcode_t op_store = 7'b0100011;

    // funct3 values, add/sub share one code
    localparam funct3_t f3_add = 3'b000;
    localparam funct3_t f3_xor = 3'b100;
    localparam funct3_t f3_or  = 3'b110;
    localparam funct3_t f3_and = 3'b111;
    localparam funct3_t f3_sw  = 3'b010;

    // funct7 for register ops, only bit 30 differs
    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_sub  = 7'b0100000;

    typedef enum logic [1:0] {
        fs_request,
        fs_wait_core,
        fs_halted
    } fetch_state_t;

    // master side of the wishbone classic bus
    typedef struct packed {
        logic    cyc;
        logic    stb;
        logic    we;
        addr_t   adr;
        wb_sel_t sel;
    } wb_req_t;

    // slave side of the bus
    typedef struct packed {
        logic  ack;
        xlen_t dat_r;
    } wb_rsp_t;

    // store word going from the core to the led port
    typedef struct packed {
        logic  valid;
        addr_t addr;
        xlen_t data;
    } store_t;

endpackage

`default_nettype wire

/* hw/reg_file.sv */
`default_nettype none

module reg_file (
    input  wire                           clock_1hz,
    input  wire                           KEY0,
    input  wire rv_board_pkg::reg_idx_t   rs1,
    input  wire rv_board_pkg::reg_idx_t   rs2,
    input  wire rv_board_pkg::reg_idx_t   rd,
    input  wire                           wr_en,
    input  wire rv_board_pkg::xlen_t      wr_data,
    output rv_board_pkg::xlen_t           rs1_data,
    output rv_board_pkg::xlen_t           rs2_data
);

    // x1..x31, x0 has no storage at all
    rv_board_pkg::xlen_t regs [1:31];

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (rd != '0)) begin
            regs[rd] <= wr_data;
        end
    end

    // combinational reads, index zero forced to zero
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    // a write aimed at x0 must be invisible on both ports afterwards
    x0_stays_zero: assert property (
        @(posedge clock_1hz) disable iff (!KEY0)
        (wr_en && (rd == '0)) |=>
            ((rs1 != '0) || (rs1_data == '0)) && ((rs2 != '0) || (rs2_data == '0)));

endmodule

`default_nettype wire

/* hw/fetch_unit.sv */
`default_nettype none

module fetch_unit (
    input  wire                          clock_1hz,
    input  wire                          KEY0,
    output rv_board_pkg::wb_req_t        wb_req,
    input  wire rv_board_pkg::wb_rsp_t   wb_rsp,
    output rv_board_pkg::instr_t         instr,
    output logic                         instr_valid,
    input  wire                          retire,
    input  wire                          illegal
);

    rv_board_pkg::fetch_state_t state;
    rv_board_pkg::addr_t        pc;

    // cyc and stb move together on a single-beat classic master
    logic req_active;

    // slave answered the pending read
    logic take_word;

    assign take_word = (state == rv_board_pkg::fs_request) && req_active && wb_rsp.ack;

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            state       <= rv_board_pkg::fs_request;
            pc          <= rv_board_pkg::reset_pc;
            req_active  <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            // handoff strobe lasts one cycle only
            instr_valid <= 1'b0;
            case (state)
                rv_board_pkg::fs_request: begin
                    if (!req_active) begin
                        // first request after reset
                        req_active <= 1'b1;
                    end else if (wb_rsp.ack) begin
                        req_active  <= 1'b0;
                        instr_valid <= 1'b1;
                        state       <= rv_board_pkg::fs_wait_core;
                    end
                end
                rv_board_pkg::fs_wait_core: begin
                    if (illegal) begin
                        state <= rv_board_pkg::fs_halted;
                    end else if (retire) begin
                        // next request goes out together with the new pc
                        pc         <= pc + 32'd4;
                        req_active <= 1'b1;
                        state      <= rv_board_pkg::fs_request;
                    end
                end
                rv_board_pkg::fs_halted: begin
                    // parked until reset
                    req_active <= 1'b0;
                end
                default: begin
                    state <= rv_board_pkg::fs_halted;
                end
            endcase
        end
    end

    // instruction register, captured in the ack cycle
    always_ff @(posedge clock_1hz) begin
        if (take_word) begin
            instr <= wb_rsp.dat_r;
        end
    end

    // read only master, whole word, address straight from the pc
    always_comb begin
        wb_req.cyc = req_active;
        wb_req.stb = req_active;
        wb_req.we  = 1'b0;
        wb_req.adr = pc;
        wb_req.sel = rv_board_pkg::wb_sel_all;
    end

    stb_needs_cyc: assert property (
        @(posedge clock_1hz) disable iff (!KEY0) wb_req.stb |-> wb_req.cyc);

    adr_held_until_ack: assert property (
        @(posedge clock_1hz) disable iff (!KEY0)
        (wb_req.stb && !wb_rsp.ack) |=> $stable(wb_req.adr));

endmodule

`default_nettype wire

/* hw/exec_core.sv */
`default_nettype none

module exec_core (
    input  wire                         clock_1hz,
    input  wire                         KEY0,
    input  wire rv_board_pkg::instr_t   instr,
    input  wire                         instr_valid,
    output logic                        retire,
    output logic                        illegal,
    output rv_board_pkg::store_t        store
);

    // instruction fields
    rv_board_pkg::opcode_t  opcode;
    rv_board_pkg::reg_idx_t rd;
    rv_board_pkg::funct3_t  funct3;
    rv_board_pkg::reg_idx_t rs1;
    rv_board_pkg::reg_idx_t rs2;
    rv_board_pkg::funct7_t  funct7;

    // sign extended i and s, u already shifted up
    rv_board_pkg::xlen_t imm_i;
    rv_board_pkg::xlen_t imm_s;
    rv_board_pkg::xlen_t imm_u;

    rv_board_pkg::xlen_t rs1_data;
    rv_board_pkg::xlen_t rs2_data;
    rv_board_pkg::xlen_t result;

    logic legal;
    logic is_store;
    logic writes_rd;
    logic wr_en;

    // registered store payload, only the valid bit sees reset
    logic                store_valid;
    rv_board_pkg::addr_t store_addr;
    rv_board_pkg::xlen_t store_data;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        legal     = 1'b0;
        is_store  = 1'b0;
        writes_rd = 1'b0;
        result    = '0;
        case (opcode)
            rv_board_pkg::op_lui: begin
                legal     = 1'b1;
                writes_rd = 1'b1;
                result    = imm_u;
            end
            rv_board_pkg::op_imm: begin
                // slti, sltiu and shifts fall through to illegal
                legal     = 1'b1;
                writes_rd = 1'b1;
                case (funct3)
                    rv_board_pkg::f3_add: result = rs1_data + imm_i;
                    rv_board_pkg::f3_xor: result = rs1_data ^ imm_i;
                    rv_board_pkg::f3_or:  result = rs1_data | imm_i;
                    rv_board_pkg::f3_and: result = rs1_data & imm_i;
                    default:              legal  = 1'b0;
                endcase
            end
            rv_board_pkg::op_reg: begin
                writes_rd = 1'b1;
                if (funct7 == rv_board_pkg::f7_base) begin
                    legal = 1'b1;
                    case (funct3)
                        rv_board_pkg::f3_add: result = rs1_data + rs2_data;
                        rv_board_pkg::f3_xor: result = rs1_data ^ rs2_data;
                        rv_board_pkg::f3_or:  result = rs1_data | rs2_data;
                        rv_board_pkg::f3_and: result = rs1_data & rs2_data;
                        default:              legal  = 1'b0;
                    endcase
                end else if ((funct7 == rv_board_pkg::f7_sub) &&
                             (funct3 == rv_board_pkg::f3_add)) begin
                    legal  = 1'b1;
                    result = rs1_data - rs2_data;
                end
            end
            rv_board_pkg::op_store: begin
                // word stores only
                if (funct3 == rv_board_pkg::f3_sw) begin
                    legal    = 1'b1;
                    is_store = 1'b1;
                end
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // writeback lands on the same edge that raises retire
    assign wr_en = instr_valid && legal && writes_rd;

    reg_file u_reg_file (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd),
        .wr_en     (wr_en),
        .wr_data   (result),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            retire      <= 1'b0;
            illegal     <= 1'b0;
            store_valid <= 1'b0;
        end else begin
            retire      <= instr_valid && legal;
            illegal     <= instr_valid && !legal;
            store_valid <= instr_valid && legal && is_store;
        end
    end

    // address decode is left to the led port
    always_ff @(posedge clock_1hz) begin
        if (instr_valid && is_store) begin
            store_addr <= rs1_data + imm_s;
            store_data <= rs2_data;
        end
    end

    assign store = '{valid: store_valid, addr: store_addr, data: store_data};

    retire_xor_illegal: assert property (
        @(posedge clock_1hz) disable iff (!KEY0) !(retire && illegal));

endmodule

`default_nettype wire

/* hw/led_port.sv */
`default_nettype none

module led_port (
    input  wire                         clock_1hz,
    input  wire                         KEY0,
    input  wire rv_board_pkg::store_t   store,
    input  wire                         retire,
    input  wire                         illegal,
    output rv_board_pkg::led_t          LEDG,
    output logic                        LEDR0,
    output logic                        LEDR9
);

    // store aimed at the led byte
    logic led_hit;

    assign led_hit = store.valid && (store.addr == rv_board_pkg::led_addr);

    always_ff @(posedge clock_1hz or negedge KEY0) begin
        if (!KEY0) begin
            LEDG  <= '0;
            LEDR0 <= 1'b0;
            LEDR9 <= 1'b0;
        end else begin
            // low byte of the stored register
            if (led_hit) begin
                LEDG <= store.data[7:0];
            end
            // heartbeat, one toggle per retired instruction
            if (retire) begin
                LEDR0 <= ~LEDR0;
            end
            // sticky, only reset clears it
            if (illegal) begin
                LEDR9 <= 1'b1;
            end
        end
    end

    // the core only issues a store as part of a retiring instruction
    store_with_retire: assert property (
        @(posedge clock_1hz) disable iff (!KEY0) store.valid |-> retire);

endmodule

`default_nettype wire

/* hw/cpu_on_board.sv */
`default_nettype none

module cpu_on_board (
    input  wire                          clock_1hz,
    input  wire                          KEY0,
    output rv_board_pkg::wb_req_t        wb_req,
    input  wire rv_board_pkg::wb_rsp_t   wb_rsp,
    output rv_board_pkg::led_t           LEDG,
    output logic                         LEDR0,
    output logic                         LEDR9
);

    // fetch to core handoff
    rv_board_pkg::instr_t instr;
    logic                 instr_valid;

    // core status pulses, seen by fetch and the leds
    logic retire;
    logic illegal;

    rv_board_pkg::store_t store;

    fetch_unit u_fetch_unit (
        .clock_1hz   (clock_1hz),
        .KEY0        (KEY0),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .instr       (instr),
        .instr_valid (instr_valid),
        .retire      (retire),
        .illegal     (illegal)
    );

    exec_core u_exec_core (
        .clock_1hz   (clock_1hz),
        .KEY0        (KEY0),
        .instr       (instr),
        .instr_valid (instr_valid),
        .retire      (retire),
        .illegal     (illegal),
        .store       (store)
    );

    led_port u_led_port (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .store     (store),
        .retire    (retire),
        .illegal   (illegal),
        .LEDG      (LEDG),
        .LEDR0     (LEDR0),
        .LEDR9     (LEDR9)
    );

endmodule

`default_nettype wire

/* tests/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// reference machine state, x0 is never written
logic [31:0] m_regs [0:31];
logic [31:0] m_pc;
logic [7:0]  m_led;
int          m_retired;
logic        m_halted;

// stops the run on the first mismatch
task automatic check_value(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    if (actual !== expected) begin
        $display("FAIL %s expected %h actual %h", name, expected, actual);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    end
endtask

task automatic reset_model();
    for (int r = 0; r < 32; r++) begin
        m_regs[r] = '0;
    end
    m_pc      = rv_board_pkg::reset_pc;
    m_led     = '0;
    m_retired = 0;
    m_halted  = 1'b0;
endtask

// one word under rv32i rules, cut down to the board subset
task automatic execute_on_model(input logic [31:0] w);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] res;
    logic        ok;
    logic        wr;
    a     = m_regs[w[19:15]];
    b     = m_regs[w[24:20]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    ok    = 1'b1;
    wr    = 1'b1;
    res   = '0;
    case (w[6:0])
        7'b0110111: res = {w[31:12], 12'h000};
        7'b0010011: begin
            case (w[14:12])
                3'b000:  res = a + imm_i;
                3'b100:  res = a ^ imm_i;
                3'b110:  res = a | imm_i;
                3'b111:  res = a & imm_i;
                default: ok = 1'b0;
            endcase
        end
        7'b0110011: begin
            // funct7 and funct3 together pick the operation
            case ({w[31:25], w[14:12]})
                10'b0000000_000: res = a + b;
                10'b0100000_000: res = a - b;
                10'b0000000_100: res = a ^ b;
                10'b0000000_110: res = a | b;
                10'b0000000_111: res = a & b;
                default:         ok = 1'b0;
            endcase
        end
        7'b0100011: begin
            wr = 1'b0;
            ok = (w[14:12] == 3'b010);
            // only the led word is visible, other addresses vanish
            if (ok && ((a + imm_s) == rv_board_pkg::led_addr)) begin
                m_led = b[7:0];
            end
        end
        default: ok = 1'b0;
    endcase
    if (!ok) begin
        m_halted = 1'b1;
    end else begin
        if (wr && (w[11:7] != 5'd0)) begin
            m_regs[w[11:7]] = res;
        end
        m_pc      = m_pc + 32'd4;
        m_retired = m_retired + 1;
    end
endtask

`endif

/* tests/cpu_on_board_tb.sv */
`default_nettype none

module cpu_on_board_tb;

    // random words before the closing illegal one
    localparam int prog_len     = 200;
    localparam int reset_cycles = 10;
    localparam int halt_watch   = 20;
    // at most 7 cycles per instruction, doubled, plus room for reset and halt watch
    localparam int timeout_cycles = 2 * prog_len * 7 + 200;

    logic                  clock_1hz;
    logic                  KEY0;
    rv_board_pkg::wb_req_t wb_req;
    rv_board_pkg::wb_rsp_t wb_rsp;
    rv_board_pkg::led_t    LEDG;
    logic                  LEDR0;
    logic                  LEDR9;

    // instruction memory, word indexed
    logic [31:0] mem [0:255];

    // memory model bookkeeping
    logic        req_open;
    logic [31:0] req_adr;
    int          wait_left;
    int          cycles;

    `include "tb_model.svh"

    cpu_on_board DUT (
        .clock_1hz (clock_1hz),
        .KEY0      (KEY0),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .LEDG      (LEDG),
        .LEDR0     (LEDR0),
        .LEDR9     (LEDR9)
    );

    always #4 clock_1hz = ~clock_1hz;

    function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    // sw with funct3 010
    function automatic logic [31:0] s_type_word(input logic [11:0] imm, input logic [4:0] rs2,
        input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    // x0 about one time in eight
    function automatic logic [4:0] pick_reg();
        return ($urandom_range(0, 7) == 0) ? 5'd0 : 5'($urandom_range(1, 31));
    endfunction

    task automatic build_program();
        logic [2:0] logic_f3 [4];
        logic [4:0] scratch;
        logic       to_led;
        int         sel;
        logic_f3 = '{3'b000, 3'b100, 3'b110, 3'b111};
        scratch  = 5'd1;
        to_led   = 1'b1;
        // beyond the program, illegal opcode tagged with the word index
        for (int k = 0; k < 256; k++) begin
            mem[k] = {k[24:0], 7'b1111111};
        end
        for (int i = 0; i < prog_len; i++) begin
            if (i % 8 == 6) begin
                // base for the next sw, upper page 2 and up never reaches the led word
                scratch = 5'($urandom_range(1, 31));
                to_led  = ($urandom_range(0, 3) != 0);
                mem[i]  = lui_word(to_led ? rv_board_pkg::led_addr[31:12] :
                                   20'($urandom_range(2, 20'hfffff)), scratch);
            end else if (i % 8 == 7) begin
                mem[i] = s_type_word(to_led ? 12'h000 : 12'($urandom), pick_reg(), scratch);
            end else begin
                sel = $urandom_range(0, 9);
                if (sel == 0) begin
                    mem[i] = lui_word(20'($urandom), pick_reg());
                end else if (sel <= 4) begin
                    mem[i] = i_type_word(12'($urandom), pick_reg(), logic_f3[sel - 1], pick_reg());
                end else if (sel <= 8) begin
                    mem[i] = r_type_word(7'b0000000, pick_reg(), pick_reg(), logic_f3[sel - 5],
                                         pick_reg());
                end else begin
                    mem[i] = r_type_word(7'b0100000, pick_reg(), pick_reg(), 3'b000, pick_reg());
                end
            end
        end
        mem[prog_len] = 32'h0000_0000;
    endtask

    task automatic check_idle_outputs();
        check_value("reset cyc", 1'b0, wb_req.cyc);
        check_value("reset stb", 1'b0, wb_req.stb);
        check_value("reset LEDG", 8'h00, LEDG);
        check_value("reset LEDR0", 1'b0, LEDR0);
        check_value("reset LEDR9", 1'b0, LEDR9);
    endtask

    // slave with 0 to 3 wait cycles, one-cycle ack
    always @(posedge clock_1hz) begin
        #1;
        if (wb_rsp.ack) begin
            wb_rsp.ack = 1'b0;
        end else if (KEY0 && wb_req.cyc && wb_req.stb) begin
            if (!req_open) begin
                // leds and pc reflect every word retired so far
                req_open  = 1'b1;
                req_adr   = wb_req.adr;
                wait_left = $urandom_range(0, 3);
                check_value("request after halt", 1'b0, m_halted);
                check_value("fetch address", m_pc, wb_req.adr);
                // read only fetch of the whole word
                check_value("bus write enable", 1'b0, wb_req.we);
                check_value("bus byte select", 4'b1111, wb_req.sel);
                check_value("LEDG", m_led, LEDG);
                check_value("LEDR0 heartbeat", 32'(m_retired % 2), LEDR0);
                check_value("LEDR9 before halt", 1'b0, LEDR9);
            end else begin
                check_value("address held until ack", req_adr, wb_req.adr);
            end
            if (wait_left == 0) begin
                wb_rsp.dat_r = mem[req_adr[9:2]];
                wb_rsp.ack   = 1'b1;
                req_open     = 1'b0;
                execute_on_model(mem[req_adr[9:2]]);
            end else begin
                wait_left = wait_left - 1;
            end
        end
    end

    always @(posedge clock_1hz) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles, the processor never halted", cycles);
            $display("Test failed");
            $fatal(1, "simulation timed out");
        end
    end

    initial begin
        void'($urandom(32'h51a68529));
        clock_1hz = 1'b0;
        KEY0      = 1'b0;
        wb_rsp    = '0;
        req_open  = 1'b0;
        req_adr   = '0;
        wait_left = 0;
        cycles    = 0;
        reset_model();
        build_program();
        repeat (reset_cycles) begin
            @(posedge clock_1hz);
            #1;
            check_idle_outputs();
        end
        KEY0 = 1'b1;
        check_idle_outputs();
        // closing zero word lights LEDR9
        while (!LEDR9) begin
            @(posedge clock_1hz);
            #1;
        end
        check_value("model halted", 1'b1, m_halted);
        check_value("heartbeat at halt", 32'(m_retired % 2), LEDR0);
        check_value("retired count", prog_len, m_retired);
        repeat (halt_watch) begin
            @(posedge clock_1hz);
            #1;
            check_value("no request after halt", 1'b0, wb_req.cyc);
        end
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* cpu_on_board.f */
+incdir+tests
hw/rv_board_pkg.sv
hw/reg_file.sv
hw/fetch_unit.sv
hw/exec_core.sv
hw/led_port.sv
hw/cpu_on_board.sv
tests/cpu_on_board_tb.sv
